// ==== hw/pcie_edge_consts.svh ====
`ifndef PCIE_EDGE_CONSTS_SVH
`define PCIE_EDGE_CONSTS_SVH

// Control shadow word from the subsystem
`define PCIE_SHDW_W        40
`define SHDW_PF_W          3
`define SHDW_VF_W          11
`define SHDW_VF_ACT_BIT    14
`define SHDW_EXT_TAG_BIT   29
`define SHDW_TAG10_BIT     30

// Single-beat TLP header
`define PCIE_HDR_W         64
`define TLP_FMT_MWR        8'h60
`define TLP_FMT_MRD        8'h20
`define TLP_FMT_CPL        8'h0A

// Wishbone CSR block
`define WB_ADR_W           4
`define WB_DAT_W           32
`define CSR_CTRL           4'd0
`define CSR_STATUS         4'd1
`define CSR_COMMITS        4'd2

`define COMMIT_FIFO_DEPTH  4

`endif

// ==== hw/pcie_ctrl_pkg.sv ====
`default_nettype none

`include "pcie_edge_consts.svh"

package pcie_ctrl_pkg;

   // Field view of the shadow word with the MSB first
   typedef struct packed {
      logic [`PCIE_SHDW_W-`SHDW_TAG10_BIT-2:0]          rsvd_hi;
      logic                                             tag10_en;
      logic                                             ext_tag;
      logic [`SHDW_EXT_TAG_BIT-`SHDW_VF_ACT_BIT-2:0]    rsvd_lo;
      logic                                             vf_active;
      logic [`SHDW_VF_W-1:0]                            vf_num;
      logic [`SHDW_PF_W-1:0]                            pf_num;
   } ctrl_shdw_fields_t;

   // Raw word as captured, or decoded into fields
   typedef union packed {
      logic [`PCIE_SHDW_W-1:0] raw;
      ctrl_shdw_fields_t       f;
   } ctrl_shdw_t;

   // Request tag size as a one-hot code
   typedef struct packed {
      logic tag_5bit;
      logic tag_8bit;
      logic tag_10bit;
   } tag_mode_t;

endpackage

`default_nettype wire

// ==== hw/pcie_tlp_pkg.sv ====
`default_nettype none

`include "pcie_edge_consts.svh"

package pcie_tlp_pkg;

   localparam int TLP_FMT_W = 8;
   localparam int TLP_TAG_W = 10;

   // Address takes what is left of the header beat
   typedef struct packed {
      logic [TLP_FMT_W-1:0]                        fmt_type;
      logic [TLP_TAG_W-1:0]                        tag;
      logic [`PCIE_HDR_W-TLP_FMT_W-TLP_TAG_W-1:0]  addr;
   } tlp_hdr_t;

endpackage

`default_nettype wire

// ==== hw/ctrl_shadow_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_edge_consts.svh"

module ctrl_shadow_tracker (
   input  logic                      fim_clk,
   input  logic                      csr_rst_n,
   input  logic                      shdw_valid,
   input  logic [`PCIE_SHDW_W-1:0]   shdw_data,
   input  logic                      force_8bit,
   output pcie_ctrl_pkg::tag_mode_t  tag_mode
);

   logic                       shdw_vld_q;
   pcie_ctrl_pkg::ctrl_shdw_t  shdw_q;
   pcie_ctrl_pkg::tag_mode_t   mode_q;
   logic                       pf0_word;

   // --------------------------------------------------
   // Capture stage
   // --------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         shdw_vld_q <= 1'b0;
      end else begin
         shdw_vld_q <= shdw_valid;
      end
   end

   always_ff @(posedge fim_clk) begin
      shdw_q.raw <= shdw_data;
   end

   // Tag mode is only meaningful for PF0 itself
   assign pf0_word = shdw_vld_q && (shdw_q.f.pf_num == '0) && !shdw_q.f.vf_active;

   // --------------------------------------------------
   // Update stage
   // --------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         mode_q <= '{tag_5bit: 1'b1, tag_8bit: 1'b0, tag_10bit: 1'b0};
      end else if (pf0_word) begin
         if (shdw_q.f.ext_tag && shdw_q.f.tag10_en) begin
            mode_q <= '{tag_5bit: 1'b0, tag_8bit: 1'b0, tag_10bit: 1'b1};
         end else if (shdw_q.f.ext_tag) begin
            mode_q <= '{tag_5bit: 1'b0, tag_8bit: 1'b1, tag_10bit: 1'b0};
         end else begin
            // Legacy 5-bit tags
            mode_q <= '{tag_5bit: 1'b1, tag_8bit: 1'b0, tag_10bit: 1'b0};
         end
      end
   end

   // Forced 8-bit mode acts without delay
   always_comb begin
      if (force_8bit) begin
         tag_mode = '{tag_5bit: 1'b0, tag_8bit: 1'b1, tag_10bit: 1'b0};
      end else begin
         tag_mode = mode_q;
      end
   end

   a_tag_onehot: assert property (@(posedge fim_clk) disable iff (!csr_rst_n)
      $onehot(tag_mode))
      else $error("tag_mode is not one-hot");

endmodule

`default_nettype wire

// ==== hw/write_commit_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_edge_consts.svh"

module write_commit_gen (
   input  logic                     fim_clk,
   input  logic                     csr_rst_n,
   input  logic                     tx_valid,
   output logic                     tx_ready,
   input  pcie_tlp_pkg::tlp_hdr_t   tx_hdr,
   output logic                     link_valid,
   input  logic                     link_ready,
   output pcie_tlp_pkg::tlp_hdr_t   link_hdr,
   output logic                     commit_valid,
   input  logic                     commit_ready,
   output pcie_tlp_pkg::tlp_hdr_t   commit_hdr,
   input  logic                     commit_en,
   output logic                     commit_pulse
);

   localparam int DEPTH = `COMMIT_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   pcie_tlp_pkg::tlp_hdr_t  mem [DEPTH];
   pcie_tlp_pkg::tlp_hdr_t  cpl_hdr;
   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        rd_ptr;
   logic [PTR_W:0]          fifo_cnt;
   logic [PTR_W:0]          credit_used;
   logic                    link_pend;
   logic                    push;
   logic                    pop;

   // An MWr waiting in the link register may still need a FIFO slot
   assign link_pend   = link_valid && (link_hdr.fmt_type == `TLP_FMT_MWR);
   assign credit_used = fifo_cnt + {{PTR_W{1'b0}}, link_pend};
   assign tx_ready    = (!link_valid || link_ready) && (credit_used < (PTR_W+1)'(DEPTH));

   // --------------------------------------------------
   // Link output register
   // --------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         link_valid <= 1'b0;
      end else begin
         if (link_valid && link_ready) link_valid <= 1'b0;
         if (tx_valid && tx_ready)     link_valid <= 1'b1;
      end
   end

   always_ff @(posedge fim_clk) begin
      if (tx_valid && tx_ready) link_hdr <= tx_hdr;
   end

   // --------------------------------------------------
   // Commit FIFO
   // --------------------------------------------------
   assign push         = link_valid && link_ready && commit_en &&
                         (link_hdr.fmt_type == `TLP_FMT_MWR);
   assign pop          = commit_valid && commit_ready;
   assign commit_pulse = push;

   always_comb begin
      cpl_hdr          = '0;
      cpl_hdr.fmt_type = `TLP_FMT_CPL;
      cpl_hdr.tag      = link_hdr.tag;
   end

   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fifo_cnt <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         fifo_cnt <= fifo_cnt + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
      end
   end

   always_ff @(posedge fim_clk) begin
      if (push) mem[wr_ptr] <= cpl_hdr;
   end

   assign commit_valid = (fifo_cnt != '0);
   assign commit_hdr   = mem[rd_ptr];

   a_no_push_full: assert property (@(posedge fim_clk) disable iff (!csr_rst_n)
      push |-> (fifo_cnt < (PTR_W+1)'(DEPTH)))
      else $error("commit FIFO pushed while full");

endmodule

`default_nettype wire

// ==== hw/rxreq_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module rxreq_merge (
   input  logic                     fim_clk,
   input  logic                     csr_rst_n,
   input  logic                     rxreq_in_valid,
   output logic                     rxreq_in_ready,
   input  pcie_tlp_pkg::tlp_hdr_t   rxreq_in_hdr,
   input  logic                     commit_valid,
   output logic                     commit_ready,
   input  pcie_tlp_pkg::tlp_hdr_t   commit_hdr,
   output logic                     rxreq_out_valid,
   input  logic                     rxreq_out_ready,
   output pcie_tlp_pkg::tlp_hdr_t   rxreq_out_hdr
);

   logic                    out_free;
   logic                    prio_commit;
   logic                    grant_commit;
   logic                    grant_host;
   pcie_tlp_pkg::tlp_hdr_t  sel_hdr;

   assign out_free = !rxreq_out_valid || rxreq_out_ready;

   // --------------------------------------------------
   // Round-robin between host requests and commits
   // --------------------------------------------------
   assign grant_commit = commit_valid && (!rxreq_in_valid || prio_commit);
   assign grant_host   = rxreq_in_valid && !grant_commit;

   assign commit_ready   = out_free && grant_commit;
   assign rxreq_in_ready = out_free && grant_host;
   assign sel_hdr        = grant_commit ? commit_hdr : rxreq_in_hdr;

   // Priority flips to the source that just lost
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         prio_commit <= 1'b0;
      end else if (out_free) begin
         if (grant_commit)    prio_commit <= 1'b0;
         else if (grant_host) prio_commit <= 1'b1;
      end
   end

   // Registered stage toward the AFU
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         rxreq_out_valid <= 1'b0;
      end else if (out_free) begin
         rxreq_out_valid <= grant_commit || grant_host;
      end
   end

   always_ff @(posedge fim_clk) begin
      if (out_free && (grant_commit || grant_host)) rxreq_out_hdr <= sel_hdr;
   end

   a_out_stable: assert property (@(posedge fim_clk) disable iff (!csr_rst_n)
      rxreq_out_valid && !rxreq_out_ready |=> rxreq_out_valid && $stable(rxreq_out_hdr))
      else $error("rxreq_out changed under back-pressure");

endmodule

`default_nettype wire

// ==== hw/edge_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_edge_consts.svh"

module edge_csr (
   input  logic                      fim_clk,
   input  logic                      csr_rst_n,
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [`WB_ADR_W-1:0]      wb_adr,
   input  logic [`WB_DAT_W-1:0]      wb_dat_w,
   output logic [`WB_DAT_W-1:0]      wb_dat_r,
   output logic                      wb_ack,
   input  pcie_ctrl_pkg::tag_mode_t  tag_mode,
   input  logic                      commit_pulse,
   output logic                      commit_en,
   output logic                      force_8bit
);

   logic                  req;
   logic                  wr_commits;
   logic [`WB_DAT_W-1:0]  commit_cnt;
   logic [`WB_DAT_W-1:0]  rd_data;

   // A new access is one not already being acked
   assign req        = wb_cyc && wb_stb && !wb_ack;
   assign wr_commits = req && wb_we && (wb_adr == `CSR_COMMITS);

   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= req;
      end
   end

   // --------------------------------------------------
   // Control register
   // --------------------------------------------------
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         commit_en  <= 1'b1;
         force_8bit <= 1'b0;
      end else if (req && wb_we && (wb_adr == `CSR_CTRL)) begin
         commit_en  <= wb_dat_w[0];
         force_8bit <= wb_dat_w[1];
      end
   end

   // A clear of the commit counter wins over a pulse in the same cycle
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n || wr_commits) begin
         commit_cnt <= '0;
      end else if (commit_pulse) begin
         commit_cnt <= commit_cnt + 1'b1;
      end
   end

   // --------------------------------------------------
   // Read path
   // --------------------------------------------------
   always_comb begin
      case (wb_adr)
         `CSR_CTRL:    rd_data = {{(`WB_DAT_W-2){1'b0}}, force_8bit, commit_en};
         `CSR_STATUS:  rd_data = {{(`WB_DAT_W-$bits(tag_mode)){1'b0}}, tag_mode};
         `CSR_COMMITS: rd_data = commit_cnt;
         default:      rd_data = '0;
      endcase
   end

   always_ff @(posedge fim_clk) begin
      if (req) wb_dat_r <= rd_data;
   end

endmodule

`default_nettype wire

// ==== hw/pcie_edge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_edge_consts.svh"

module pcie_edge_top (
   input  logic                      fim_clk,
   input  logic                      csr_rst_n,
   // Control shadow
   input  logic                      shdw_valid,
   input  logic [`PCIE_SHDW_W-1:0]   shdw_data,
   output pcie_ctrl_pkg::tag_mode_t  tag_mode,
   // FPGA to host TX and the link
   input  logic                      tx_valid,
   output logic                      tx_ready,
   input  pcie_tlp_pkg::tlp_hdr_t    tx_hdr,
   output logic                      link_valid,
   input  logic                      link_ready,
   output pcie_tlp_pkg::tlp_hdr_t    link_hdr,
   // Host RXREQ and the AFU side
   input  logic                      rxreq_in_valid,
   output logic                      rxreq_in_ready,
   input  pcie_tlp_pkg::tlp_hdr_t    rxreq_in_hdr,
   output logic                      rxreq_out_valid,
   input  logic                      rxreq_out_ready,
   output pcie_tlp_pkg::tlp_hdr_t    rxreq_out_hdr,
   // Wishbone
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [`WB_ADR_W-1:0]      wb_adr,
   input  logic [`WB_DAT_W-1:0]      wb_dat_w,
   output logic [`WB_DAT_W-1:0]      wb_dat_r,
   output logic                      wb_ack
);

   logic                    commit_valid;
   logic                    commit_ready;
   pcie_tlp_pkg::tlp_hdr_t  commit_hdr;
   logic                    commit_pulse;
   logic                    commit_en;
   logic                    force_8bit;

   ctrl_shadow_tracker shdw_i (
      .fim_clk    (fim_clk),
      .csr_rst_n  (csr_rst_n),
      .shdw_valid (shdw_valid),
      .shdw_data  (shdw_data),
      .force_8bit (force_8bit),
      .tag_mode   (tag_mode)
   );

   write_commit_gen commit_i (
      .fim_clk      (fim_clk),
      .csr_rst_n    (csr_rst_n),
      .tx_valid     (tx_valid),
      .tx_ready     (tx_ready),
      .tx_hdr       (tx_hdr),
      .link_valid   (link_valid),
      .link_ready   (link_ready),
      .link_hdr     (link_hdr),
      .commit_valid (commit_valid),
      .commit_ready (commit_ready),
      .commit_hdr   (commit_hdr),
      .commit_en    (commit_en),
      .commit_pulse (commit_pulse)
   );

   rxreq_merge merge_i (
      .fim_clk         (fim_clk),
      .csr_rst_n       (csr_rst_n),
      .rxreq_in_valid  (rxreq_in_valid),
      .rxreq_in_ready  (rxreq_in_ready),
      .rxreq_in_hdr    (rxreq_in_hdr),
      .commit_valid    (commit_valid),
      .commit_ready    (commit_ready),
      .commit_hdr      (commit_hdr),
      .rxreq_out_valid (rxreq_out_valid),
      .rxreq_out_ready (rxreq_out_ready),
      .rxreq_out_hdr   (rxreq_out_hdr)
   );

   edge_csr csr_i (
      .fim_clk      (fim_clk),
      .csr_rst_n    (csr_rst_n),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .tag_mode     (tag_mode),
      .commit_pulse (commit_pulse),
      .commit_en    (commit_en),
      .force_8bit   (force_8bit)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_pcie_edge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_edge_consts.svh"

module tb_pcie_edge;

   localparam int N_TX        = 600;
   localparam int N_RX        = 600;
   localparam int N_TX_OFF    = 120;
   localparam int N_SHDW      = 64;
   localparam int TIMEOUT_CYC = 20 * (N_TX + N_RX);

   localparam pcie_ctrl_pkg::tag_mode_t MODE_5B =
      '{tag_5bit: 1'b1, tag_8bit: 1'b0, tag_10bit: 1'b0};
   localparam pcie_ctrl_pkg::tag_mode_t MODE_8B =
      '{tag_5bit: 1'b0, tag_8bit: 1'b1, tag_10bit: 1'b0};
   localparam pcie_ctrl_pkg::tag_mode_t MODE_10B =
      '{tag_5bit: 1'b0, tag_8bit: 1'b0, tag_10bit: 1'b1};

   logic                      fim_clk;
   logic                      csr_rst_n;
   logic                      shdw_valid;
   logic [`PCIE_SHDW_W-1:0]   shdw_data;
   pcie_ctrl_pkg::tag_mode_t  tag_mode;
   logic                      tx_valid;
   logic                      tx_ready;
   pcie_tlp_pkg::tlp_hdr_t    tx_hdr;
   logic                      link_valid;
   logic                      link_ready;
   pcie_tlp_pkg::tlp_hdr_t    link_hdr;
   logic                      rxreq_in_valid;
   logic                      rxreq_in_ready;
   pcie_tlp_pkg::tlp_hdr_t    rxreq_in_hdr;
   logic                      rxreq_out_valid;
   logic                      rxreq_out_ready;
   pcie_tlp_pkg::tlp_hdr_t    rxreq_out_hdr;
   logic                      wb_cyc;
   logic                      wb_stb;
   logic                      wb_we;
   logic [`WB_ADR_W-1:0]      wb_adr;
   logic [`WB_DAT_W-1:0]      wb_dat_w;
   logic [`WB_DAT_W-1:0]      wb_dat_r;
   logic                      wb_ack;

   // Reference model state
   pcie_tlp_pkg::tlp_hdr_t    link_q[$];
   pcie_tlp_pkg::tlp_hdr_t    commit_q[$];
   pcie_tlp_pkg::tlp_hdr_t    host_q[$];
   pcie_ctrl_pkg::tag_mode_t  tracked_m;
   logic                      commit_en_m;
   logic                      force_m;
   int                        commit_cnt_m;
   logic                      stall;
   int                        cycles;
   int                        errors;

   pcie_edge_top dut_i (
      .fim_clk (fim_clk), .csr_rst_n (csr_rst_n),
      .shdw_valid (shdw_valid), .shdw_data (shdw_data), .tag_mode (tag_mode),
      .tx_valid (tx_valid), .tx_ready (tx_ready), .tx_hdr (tx_hdr),
      .link_valid (link_valid), .link_ready (link_ready), .link_hdr (link_hdr),
      .rxreq_in_valid (rxreq_in_valid), .rxreq_in_ready (rxreq_in_ready),
      .rxreq_in_hdr (rxreq_in_hdr), .rxreq_out_valid (rxreq_out_valid),
      .rxreq_out_ready (rxreq_out_ready), .rxreq_out_hdr (rxreq_out_hdr),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
   );

   initial fim_clk = 1'b0;
   always #4 fim_clk = ~fim_clk;

   // --------------------------------------------------
   // Error handling and compare tasks
   // --------------------------------------------------
   task automatic stop_on_error(input string msg);
      errors++;
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_hdr(input pcie_tlp_pkg::tlp_hdr_t got, exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("Error at %0t ns: %s got %h, expected %h",
                                 $time, what, got, exp));
   endtask

   task automatic check_mode(input pcie_ctrl_pkg::tag_mode_t got, exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("Error at %0t ns: %s got %b, expected %b",
                                 $time, what, got, exp));
   endtask

   task automatic check_wb(input logic [`WB_DAT_W-1:0] got, exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("Error at %0t ns: %s got %h, expected %h",
                                 $time, what, got, exp));
   endtask

   always @(posedge fim_clk) begin
      cycles++;
      if (cycles > TIMEOUT_CYC)
         stop_on_error($sformatf("Timeout after %0d cycles, the DUT seems to hang", cycles));
   end

   // --------------------------------------------------
   // Stimulus helpers
   // --------------------------------------------------
   function automatic pcie_tlp_pkg::tlp_hdr_t rand_hdr();
      pcie_tlp_pkg::tlp_hdr_t h;
      h = {$urandom, $urandom};
      h.fmt_type = ($urandom % 2) ? `TLP_FMT_MWR : `TLP_FMT_MRD;
      return h;
   endfunction

   // Tag mode rules apply to PF0 words with VF active clear
   function automatic pcie_ctrl_pkg::tag_mode_t mode_for(input logic [`PCIE_SHDW_W-1:0] w,
                                                        input pcie_ctrl_pkg::tag_mode_t cur);
      if (w[`SHDW_PF_W-1:0] != '0 || w[`SHDW_VF_ACT_BIT])
         return cur;
      if (w[`SHDW_EXT_TAG_BIT] && w[`SHDW_TAG10_BIT])
         return MODE_10B;
      if (w[`SHDW_EXT_TAG_BIT])
         return MODE_8B;
      return MODE_5B;
   endfunction

   task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                            input logic [`WB_DAT_W-1:0] wdat, output logic [`WB_DAT_W-1:0] rdat);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = adr;
      wb_dat_w = wdat;
      do begin
         @(posedge fim_clk);
         #1;
      end while (!wb_ack);
      rdat = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      @(posedge fim_clk);
      #1;
      if (wb_ack)
         stop_on_error("Wishbone ack stayed high for more than one cycle");
   endtask

   task automatic shdw_step();
      logic [`PCIE_SHDW_W-1:0] w;
      w = {$urandom, $urandom};
      if ($urandom % 2) begin
         w[`SHDW_PF_W-1:0] = '0;
         w[`SHDW_VF_ACT_BIT] = 1'b0;
      end
      shdw_valid = 1'b1;
      shdw_data = w;
      @(posedge fim_clk);
      #1;
      shdw_valid = 1'b0;
      @(posedge fim_clk);
      #1;
      tracked_m = mode_for(w, tracked_m);
      check_mode(tag_mode, force_m ? MODE_8B : tracked_m, "tag_mode after shadow word");
   endtask

   task automatic tx_drive(input int n);
      pcie_tlp_pkg::tlp_hdr_t h;
      for (int i = 0; i < n; i++) begin
         h = rand_hdr();
         tx_valid = 1'b1;
         tx_hdr = h;
         do begin
            @(posedge fim_clk);
         end while (!tx_ready);
         link_q.push_back(h);
         #1;
         tx_valid = 1'b0;
         repeat ($urandom % 3) begin
            @(posedge fim_clk);
            #1;
         end
      end
   endtask

   task automatic host_drive(input int n);
      pcie_tlp_pkg::tlp_hdr_t h;
      for (int i = 0; i < n; i++) begin
         h = rand_hdr();
         rxreq_in_valid = 1'b1;
         rxreq_in_hdr = h;
         do begin
            @(posedge fim_clk);
         end while (!rxreq_in_ready);
         host_q.push_back(h);
         #1;
         rxreq_in_valid = 1'b0;
         repeat ($urandom % 3) begin
            @(posedge fim_clk);
            #1;
         end
      end
   endtask

   task automatic stall_burst();
      repeat (150) @(posedge fim_clk);
      stall = 1'b1;
      repeat (60) @(posedge fim_clk);
      stall = 1'b0;
   endtask

   task automatic drain();
      while (link_q.size() != 0 || commit_q.size() != 0 || host_q.size() != 0)
         @(posedge fim_clk);
      repeat (20) @(posedge fim_clk);
      #1;
   endtask

   // Random back-pressure on both output streams
   always @(posedge fim_clk) begin
      #1;
      link_ready = ($urandom % 4) != 0;
      rxreq_out_ready = !stall && (($urandom % 3) != 0);
   end

   // --------------------------------------------------
   // Output monitors
   // --------------------------------------------------
   always @(posedge fim_clk) begin
      pcie_tlp_pkg::tlp_hdr_t exp;
      pcie_tlp_pkg::tlp_hdr_t cpl;
      if (csr_rst_n && link_valid && link_ready) begin
         if (link_q.size() == 0) begin
            stop_on_error("Link carried an item that was never sent");
         end else begin
            exp = link_q.pop_front();
            check_hdr(link_hdr, exp, "link header");
            if (exp.fmt_type == `TLP_FMT_MWR && commit_en_m) begin
               cpl = '0;
               cpl.fmt_type = `TLP_FMT_CPL;
               cpl.tag = exp.tag;
               commit_q.push_back(cpl);
               commit_cnt_m++;
            end
         end
      end
   end

   always @(posedge fim_clk) begin
      if (csr_rst_n && rxreq_out_valid && rxreq_out_ready) begin
         if (rxreq_out_hdr.fmt_type == `TLP_FMT_CPL) begin
            if (commit_q.size() == 0)
               stop_on_error("A commit completion reached the AFU with none expected");
            else
               check_hdr(rxreq_out_hdr, commit_q.pop_front(), "commit on rxreq_out");
         end else begin
            if (host_q.size() == 0)
               stop_on_error("A host request reached the AFU with none expected");
            else
               check_hdr(rxreq_out_hdr, host_q.pop_front(), "host item on rxreq_out");
         end
      end
   end

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      logic [`WB_DAT_W-1:0] rd;
      void'($urandom(32'hc9066ff5));
      csr_rst_n = 1'b0;
      {shdw_valid, shdw_data, tx_valid, tx_hdr, rxreq_in_valid, rxreq_in_hdr} = '0;
      {link_ready, rxreq_out_ready, wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
      stall = 1'b0;
      cycles = 0;
      errors = 0;
      tracked_m = MODE_5B;
      commit_en_m = 1'b1;
      force_m = 1'b0;
      commit_cnt_m = 0;
      repeat (2) @(posedge fim_clk);
      #1;
      csr_rst_n = 1'b1;
      if (link_valid || rxreq_out_valid || wb_ack)
         stop_on_error("An output valid or wb_ack is high after reset");
      check_mode(tag_mode, MODE_5B, "tag_mode after reset");
      wb_access(1'b0, `CSR_CTRL, '0, rd);
      check_wb(rd, 32'h1, "CSR_CTRL after reset");
      wb_access(1'b0, `CSR_COMMITS, '0, rd);
      check_wb(rd, 32'h0, "CSR_COMMITS after reset");
      wb_access(1'b0, 4'hf, '0, rd);
      check_wb(rd, 32'h0, "unknown CSR address");

      repeat (N_SHDW) shdw_step();

      // Force 8-bit mode and then return to the tracked mode
      wb_access(1'b1, `CSR_CTRL, 32'h3, rd);
      force_m = 1'b1;
      check_mode(tag_mode, MODE_8B, "tag_mode with force_8bit");
      wb_access(1'b0, `CSR_STATUS, '0, rd);
      check_wb(rd, {{(`WB_DAT_W-3){1'b0}}, MODE_8B}, "CSR_STATUS with force_8bit");
      repeat (8) shdw_step();
      wb_access(1'b1, `CSR_CTRL, 32'h1, rd);
      force_m = 1'b0;
      check_mode(tag_mode, tracked_m, "tag_mode after force_8bit cleared");
      wb_access(1'b0, `CSR_STATUS, '0, rd);
      check_wb(rd, {{(`WB_DAT_W-3){1'b0}}, tracked_m}, "CSR_STATUS after force_8bit cleared");

      fork
         tx_drive(N_TX - N_TX_OFF);
         host_drive(N_RX);
         stall_burst();
      join
      drain();
      wb_access(1'b0, `CSR_COMMITS, '0, rd);
      check_wb(rd, commit_cnt_m, "CSR_COMMITS after traffic");

      // No commits while commit generation is off
      wb_access(1'b1, `CSR_CTRL, 32'h0, rd);
      commit_en_m = 1'b0;
      tx_drive(N_TX_OFF);
      drain();
      wb_access(1'b0, `CSR_COMMITS, '0, rd);
      check_wb(rd, commit_cnt_m, "CSR_COMMITS with commit_en cleared");
      wb_access(1'b1, `CSR_COMMITS, '0, rd);
      commit_cnt_m = 0;
      wb_access(1'b0, `CSR_COMMITS, '0, rd);
      check_wb(rd, 32'h0, "CSR_COMMITS after clear");
      wb_access(1'b1, `CSR_CTRL, 32'h1, rd);

      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/pcie_ctrl_pkg.sv
hw/pcie_tlp_pkg.sv
hw/ctrl_shadow_tracker.sv
hw/write_commit_gen.sv
hw/rxreq_merge.sv
hw/edge_csr.sv
hw/pcie_edge_top.sv
testbench/tb_pcie_edge.sv
